/* common/nabp_types_pkg.sv */
`default_nettype none

// data types shared by filter, filtered RAM and reader
package nabp_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raw host sample
    localparam int SAMPLE_W = 12;
    // filtered sample, two extra bits for the FIR gain of four
    localparam int FSAMPLE_W = 14;
    // angle tag
    localparam int ANGLE_W = 9;
    // per-angle interpolated sum
    localparam int SUM_W = 20;
    // sample index, caps a line at 16 samples
    localparam int S_W = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [FSAMPLE_W-1:0] fsample_t;
    typedef logic [ANGLE_W-1:0] angle_t;
    typedef logic signed [SUM_W-1:0] sum_t;

endpackage

`default_nettype wire

/* common/nabp_ctrl_pkg.sv */
`default_nettype none

// filtered RAM swap control encodings
package nabp_ctrl_pkg;

    // fill/work state machine
    typedef enum logic [2:0] {
        ready_st         = 3'd0,
        fill_st          = 3'd1,
        fill_and_work_st = 3'd2,
        work_st          = 3'd3
    } swap_state_t;

    // bank_sel names the bank being filled
    // the other bank is the working bank
    typedef enum logic {
        sel_bank0 = 1'b0,
        sel_bank1 = 1'b1
    } bank_sel_t;

endpackage

`default_nettype wire

/* common/filtered_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// filtered sample stream, one sample per strobe, no back-pressure
interface filtered_stream_if import nabp_types_pkg::*; ();

    // one-cycle strobe per filtered sample
    logic strobe;
    // position of the sample in the line
    logic [S_W-1:0] index;
    fsample_t value;
    // high with the final index of a line
    logic last;

    // filter side
    modport source (output strobe, output index, output value, output last);
    // filtered RAM side
    modport sink (input strobe, input index, input value, input last);

endinterface

`default_nettype wire

/* design/projection_filter.sv */
`timescale 1ns/1ps
`default_nettype none

// three-tap ramp smoothing FIR over one host projection line
// y[i] = x[i-1] + 2*x[i] + x[i+1], samples outside the line are zero
module projection_filter import nabp_types_pkg::*; #(
    parameter int NUM_S = 16
) (
    input  wire     clk,
    input  wire     reset_n,
    input  wire     hs_start,
    input  wire     hs_strobe,
    input  sample_t hs_sample,
    filtered_stream_if.source fout
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // count of samples taken in the current line
    logic [S_W-1:0] in_cnt;
    // index of the sample arriving now
    logic [S_W-1:0] in_idx;
    // history, hist1 is the newest sample and hist0 the one before it
    sample_t hist0;
    sample_t hist1;
    // one cycle after the last input, emits the final output
    logic flush_pend;

    // hs_start arrives with sample zero
    assign in_idx = hs_start ? '0 : in_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // three-tap sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fsample_t right_tap;
    fsample_t tap_sum;

    // right neighbour is zero past the end of the line
    assign right_tap = flush_pend ? '0 : fsample_t'(hs_sample);
    assign tap_sum = fsample_t'(hist0) + (fsample_t'(hist1) <<< 1) + right_tap;

    // counters and strobes
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            in_cnt      <= '0;
            flush_pend  <= 1'b0;
            fout.strobe <= 1'b0;
            fout.last   <= 1'b0;
        end
        else
        begin
            flush_pend  <= hs_strobe && (in_idx == S_W'(NUM_S - 1));
            // sample zero only loads history, y[i] follows x[i+1]
            fout.strobe <= (hs_strobe && (in_idx != '0)) || flush_pend;
            fout.last   <= flush_pend;
            if (hs_strobe)
                in_cnt <= in_idx + 1'b1;
        end
    end

    // history and output payload
    always_ff @(posedge clk)
    begin
        if (hs_strobe)
        begin
            // a new line starts with an empty left neighbour
            hist0 <= hs_start ? '0 : hist1;
            hist1 <= hs_sample;
            fout.index <= in_idx - 1'b1;
            fout.value <= tap_sum;
        end
        else if (flush_pend)
        begin
            fout.index <= S_W'(NUM_S - 1);
            fout.value <= tap_sum;
        end
    end

endmodule

`default_nettype wire

/* filtered_ram/filtered_ram_swappable.sv */
`timescale 1ns/1ps
`default_nettype none

// one filtered RAM bank
// single write port, two registered read ports, fill-done flag
module filtered_ram_swappable import nabp_types_pkg::*; #(
    parameter int NUM_S = 16
) (
    input  wire            clk,
    input  wire            reset_n,
    // write side, from the filter stream
    input  wire            wr_en,
    input  wire [S_W-1:0]  wr_addr,
    input  fsample_t       wr_data,
    // read side, neighbouring positions from the reader
    input  wire [S_W-1:0]  rd0_addr,
    input  wire [S_W-1:0]  rd1_addr,
    // drops the fill-done flag when the bank is released
    input  wire            clear,
    output fsample_t       rd0_data,
    output fsample_t       rd1_data,
    output logic           filled
);

    // register array, one entry per sample position
    fsample_t mem [NUM_S];

    // write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // dual read, data one cycle after the address
    always_ff @(posedge clk)
    begin
        rd0_data <= mem[rd0_addr];
        rd1_data <= mem[rd1_addr];
    end

    // bank is full once the last position has been written
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            filled <= 1'b0;
        else if (clear)
            filled <= 1'b0;
        else if (wr_en && (wr_addr == S_W'(NUM_S - 1)))
            filled <= 1'b1;
    end

endmodule

`default_nettype wire

/* filtered_ram/filtered_ram_swap_control.sv */
`timescale 1ns/1ps
`default_nettype none

// ping-pong filtered RAM
// one bank fills from the filter while the other is read by the reader
module filtered_ram_swap_control
    import nabp_types_pkg::*;
    import nabp_ctrl_pkg::*;
#(
    parameter int NUM_S = 16
) (
    input  wire            clk,
    input  wire            reset_n,
    // host line start
    input  wire            hs_start,
    input  angle_t         hs_angle,
    // filtered samples
    filtered_stream_if.sink fin,
    // reader side
    input  wire [S_W-1:0]  rd0_addr,
    input  wire [S_W-1:0]  rd1_addr,
    input  wire            bank_release,
    output logic           hs_ready,
    output logic           work_start,
    output angle_t         work_angle,
    output fsample_t       rd0_data,
    output fsample_t       rd1_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    swap_state_t state;
    // filling bank, the other one is worked
    bank_sel_t bank_sel;
    // a host line has started and its last sample is not yet in
    logic line_open;
    // angle of the line in the filling bank
    angle_t fill_angle;
    // filling bank is complete
    logic fill_filled;
    // filling bank becomes the working bank
    logic swap;

    // bank signals
    logic     b0_wr_en;
    logic     b1_wr_en;
    logic     b0_clear;
    logic     b1_clear;
    logic     b0_filled;
    logic     b1_filled;
    fsample_t b0_rd0_data;
    fsample_t b0_rd1_data;
    fsample_t b1_rd0_data;
    fsample_t b1_rd1_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // steering by bank_sel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writes go to the filling bank only
    assign b0_wr_en = fin.strobe && (bank_sel == sel_bank0);
    assign b1_wr_en = fin.strobe && (bank_sel == sel_bank1);
    // release empties the working bank
    assign b0_clear = bank_release && (bank_sel == sel_bank1);
    assign b1_clear = bank_release && (bank_sel == sel_bank0);
    assign fill_filled = (bank_sel == sel_bank0) ? b0_filled : b1_filled;
    // reads come from the working bank
    assign rd0_data = (bank_sel == sel_bank0) ? b1_rd0_data : b0_rd0_data;
    assign rd1_data = (bank_sel == sel_bank0) ? b1_rd1_data : b0_rd1_data;

    // swap right away when nothing is worked, else wait for the release
    assign swap = fill_filled &&
                  ((state == fill_st) || ((state == fill_and_work_st) && bank_release));

    // host may start a line when the filling bank is free
    assign hs_ready = !line_open &&
                      ((state == ready_st) ||
                       (((state == fill_and_work_st) || (state == work_st)) && !fill_filled));

    // fill/work state machine
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= ready_st;
            bank_sel   <= sel_bank0;
            line_open  <= 1'b0;
            work_start <= 1'b0;
        end
        else
        begin
            work_start <= swap;
            if (swap)
                bank_sel <= (bank_sel == sel_bank0) ? sel_bank1 : sel_bank0;
            if (hs_start)
                line_open <= 1'b1;
            else if (fin.strobe && fin.last)
                line_open <= 1'b0;

            case (state)
                ready_st:
                    if (hs_start)
                        state <= fill_st;
                fill_st:
                    if (swap)
                        state <= work_st;
                work_st:
                    // release and a new line may land together
                    if (bank_release && hs_start)
                        state <= fill_st;
                    else if (bank_release)
                        state <= ready_st;
                    else if (hs_start)
                        state <= fill_and_work_st;
                fill_and_work_st:
                    if (swap)
                        state <= work_st;
                    else if (bank_release)
                        state <= fill_st;
                default:
                    state <= ready_st;
            endcase
        end
    end

    // angle hand-over, latched at line start and passed on at the swap
    always_ff @(posedge clk)
    begin
        if (hs_start)
            fill_angle <= hs_angle;
        if (swap)
            work_angle <= fill_angle;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // banks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    filtered_ram_swappable #(.NUM_S(NUM_S)) u_bank0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr_en    (b0_wr_en),
        .wr_addr  (fin.index),
        .wr_data  (fin.value),
        .rd0_addr (rd0_addr),
        .rd1_addr (rd1_addr),
        .clear    (b0_clear),
        .rd0_data (b0_rd0_data),
        .rd1_data (b0_rd1_data),
        .filled   (b0_filled)
    );

    filtered_ram_swappable #(.NUM_S(NUM_S)) u_bank1 (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr_en    (b1_wr_en),
        .wr_addr  (fin.index),
        .wr_data  (fin.value),
        .rd0_addr (rd0_addr),
        .rd1_addr (rd1_addr),
        .clear    (b1_clear),
        .rd0_data (b1_rd0_data),
        .rd1_data (b1_rd1_data),
        .filled   (b1_filled)
    );

endmodule

`default_nettype wire

/* design/backprojection_reader.sv */
`timescale 1ns/1ps
`default_nettype none

// walks the working bank and sums midpoint interpolations for one angle
// sum over s of (f[s] + f[s+1]) >>> 1, s from 0 to NUM_S-2
module backprojection_reader import nabp_types_pkg::*; #(
    parameter int NUM_S = 16
) (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             work_start,
    input  angle_t          work_angle,
    input  fsample_t        rd0_data,
    input  fsample_t        rd1_data,
    output logic [S_W-1:0]  rd0_addr,
    output logic [S_W-1:0]  rd1_addr,
    output logic            bank_release,
    output logic            res_strobe,
    output angle_t          res_angle,
    output sum_t            res_sum
);

    // address pairs being issued
    logic active;
    // read data valid, one cycle behind the address
    logic valid_d;
    // final pair of the line
    logic last_d;
    sum_t acc;

    // midpoint term, one extra bit so the pair sum never wraps
    logic signed [FSAMPLE_W:0] pair_sum;
    logic signed [FSAMPLE_W:0] half_term;

    assign pair_sum  = rd0_data + rd1_data;
    assign half_term = pair_sum >>> 1;
    // right-hand neighbour of the current position
    assign rd1_addr  = rd0_addr + 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address walk and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            active       <= 1'b0;
            valid_d      <= 1'b0;
            last_d       <= 1'b0;
            rd0_addr     <= '0;
            res_strobe   <= 1'b0;
            bank_release <= 1'b0;
        end
        else
        begin
            valid_d <= active;
            last_d  <= active && (rd0_addr == S_W'(NUM_S - 2));
            // result and release leave NUM_S+1 cycles after work_start
            res_strobe   <= valid_d && last_d;
            bank_release <= valid_d && last_d;
            if (work_start)
            begin
                active   <= 1'b1;
                rd0_addr <= '0;
            end
            else if (active)
            begin
                if (rd0_addr == S_W'(NUM_S - 2))
                    active <= 1'b0;
                else
                    rd0_addr <= rd0_addr + 1'b1;
            end
        end
    end

    // accumulator and result payload
    always_ff @(posedge clk)
    begin
        if (work_start)
        begin
            acc       <= '0;
            res_angle <= work_angle;
        end
        else if (valid_d)
        begin
            acc <= acc + sum_t'(half_term);
            if (last_d)
                res_sum <= acc + sum_t'(half_term);
        end
    end

endmodule

`default_nettype wire

/* design/nabp_filtered_top.sv */
`timescale 1ns/1ps
`default_nettype none

// filtered projection front end
// host line -> FIR -> ping-pong filtered RAM -> interpolating reader
module nabp_filtered_top import nabp_types_pkg::*; #(
    parameter int NUM_S = 16
) (
    input  wire     clk,
    input  wire     reset_n,
    // host line input
    input  wire     hs_start,
    input  wire     hs_strobe,
    input  angle_t  hs_angle,
    input  sample_t hs_sample,
    output logic    hs_ready,
    // one result per angle
    output logic    res_strobe,
    output angle_t  res_angle,
    output sum_t    res_sum
);

    // filter to filtered RAM
    filtered_stream_if fs ();

    // reader to filtered RAM
    logic [S_W-1:0] rd0_addr;
    logic [S_W-1:0] rd1_addr;
    fsample_t       rd0_data;
    fsample_t       rd1_data;
    logic           work_start;
    angle_t         work_angle;
    logic           bank_release;

    // producer
    projection_filter #(.NUM_S(NUM_S)) u_filter (
        .clk       (clk),
        .reset_n   (reset_n),
        .hs_start  (hs_start),
        .hs_strobe (hs_strobe),
        .hs_sample (hs_sample),
        .fout      (fs.source)
    );

    // ping-pong buffer
    filtered_ram_swap_control #(.NUM_S(NUM_S)) u_swap_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .hs_start     (hs_start),
        .hs_angle     (hs_angle),
        .fin          (fs.sink),
        .rd0_addr     (rd0_addr),
        .rd1_addr     (rd1_addr),
        .bank_release (bank_release),
        .hs_ready     (hs_ready),
        .work_start   (work_start),
        .work_angle   (work_angle),
        .rd0_data     (rd0_data),
        .rd1_data     (rd1_data)
    );

    // consumer
    backprojection_reader #(.NUM_S(NUM_S)) u_reader (
        .clk          (clk),
        .reset_n      (reset_n),
        .work_start   (work_start),
        .work_angle   (work_angle),
        .rd0_data     (rd0_data),
        .rd1_data     (rd1_data),
        .rd0_addr     (rd0_addr),
        .rd1_addr     (rd1_addr),
        .bank_release (bank_release),
        .res_strobe   (res_strobe),
        .res_angle    (res_angle),
        .res_sum      (res_sum)
    );

endmodule

`default_nettype wire

/* verification/nabp_filtered_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the filtered projection front end
// lines come from the data file, results are checked in arrival order
module nabp_filtered_tb import nabp_types_pkg::*; ();

    localparam int NUM_S = 16;
    localparam int NUM_LINES = 6;
    // angle, NUM_S samples, expected sum
    localparam int LINE_WORDS = NUM_S + 2;
    localparam int HALF_PERIOD = 20;
    localparam int READY_TIMEOUT = 200;
    localparam int RESULT_TIMEOUT = 1000;
    // quiet cycles watched after the last result
    localparam int TAIL_CYCLES = 60;

    logic    clk;
    logic    reset_n;
    logic    hs_start;
    logic    hs_strobe;
    angle_t  hs_angle;
    sample_t hs_sample;
    logic    hs_ready;
    logic    res_strobe;
    angle_t  res_angle;
    sum_t    res_sum;

    logic [19:0] testdata [0:NUM_LINES*LINE_WORDS-1];
    logic [31:0] rng_state;
    int          lines_started;
    logic        start_seen;

    nabp_filtered_top #(.NUM_S(NUM_S)) u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .hs_start   (hs_start),
        .hs_strobe  (hs_strobe),
        .hs_angle   (hs_angle),
        .hs_sample  (hs_sample),
        .hs_ready   (hs_ready),
        .res_strobe (res_strobe),
        .res_angle  (res_angle),
        .res_sum    (res_sum)
    );

    // 40 ns clock
    always #HALF_PERIOD clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // xorshift32 step for strobe gaps
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic signed [31:0] actual,
                               input logic signed [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
                     $time, name, actual, expected);
            stop_on_error("value mismatch");
        end
    endtask

    // returns on a rising edge where hs_ready is high
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!hs_ready)
        begin
            cycles++;
            if (cycles > READY_TIMEOUT)
                stop_on_error("timeout: hs_ready stayed low too long");
            @(posedge clk);
        end
    endtask

    // called on a rising edge, drives one full host line
    task automatic send_line(input int line);
        int base;
        int gap;
        base = line * LINE_WORDS;
        hs_start  <= 1'b1;
        hs_strobe <= 1'b1;
        hs_angle  <= angle_t'(testdata[base][ANGLE_W-1:0]);
        hs_sample <= sample_t'(testdata[base + 1][SAMPLE_W-1:0]);
        lines_started++;
        for (int i = 1; i < NUM_S; i++)
        begin
            // odd lines get random idle gaps
            rng_state = xorshift32(rng_state);
            gap = (line % 2 == 1) ? int'(rng_state % 4) : 0;
            repeat (gap)
            begin
                @(posedge clk);
                hs_start  <= 1'b0;
                hs_strobe <= 1'b0;
            end
            @(posedge clk);
            hs_start  <= 1'b0;
            hs_strobe <= 1'b1;
            hs_sample <= sample_t'(testdata[base + 1 + i][SAMPLE_W-1:0]);
        end
        @(posedge clk);
        hs_strobe <= 1'b0;
    endtask

    // waits for one result and compares it with the data file
    task automatic collect_result(input int k);
        int   cycles;
        sum_t exp_sum;
        cycles = 0;
        @(posedge clk);
        while (!res_strobe)
        begin
            cycles++;
            if (cycles > RESULT_TIMEOUT)
                stop_on_error("timeout: no result arrived for a line that was sent");
            @(posedge clk);
        end
        if (lines_started <= k)
            stop_on_error("a result appeared before its line was sent");
        exp_sum = sum_t'(testdata[k * LINE_WORDS + NUM_S + 1]);
        check_value("res_angle", res_angle, testdata[k * LINE_WORDS][ANGLE_W-1:0]);
        check_value("res_sum", res_sum, exp_sum);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hs_ready around hs_start
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk)
    begin
        if (!reset_n)
            start_seen <= 1'b0;
        else
        begin
            // ready must drop one cycle after the start
            if (start_seen)
                check_value("hs_ready after hs_start", hs_ready, 0);
            if (hs_start)
                check_value("hs_ready at hs_start", hs_ready, 1);
            start_seen <= hs_start;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        clk           = 1'b0;
        reset_n       = 1'b0;
        hs_start      = 1'b0;
        hs_strobe     = 1'b0;
        hs_angle      = '0;
        hs_sample     = '0;
        rng_state     = 32'hb16cff1d;
        lines_started = 0;
        $readmemh("verification/nabp_testdata.hex", testdata);
        if ($isunknown(testdata[NUM_LINES*LINE_WORDS-1]))
            stop_on_error("test data file could not be read");

        // reset for two cycles
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        // idle after reset, ready high and no results
        repeat (4)
        begin
            @(posedge clk);
            check_value("hs_ready", hs_ready, 1);
            check_value("res_strobe", res_strobe, 0);
        end

        fork
            // host side, each line starts as soon as ready rises
            for (int line = 0; line < NUM_LINES; line++)
            begin
                wait_ready();
                send_line(line);
            end
            // result side, in line order
            for (int k = 0; k < NUM_LINES; k++)
                collect_result(k);
        join

        // exactly one result per line
        repeat (TAIL_CYCLES)
        begin
            @(posedge clk);
            check_value("res_strobe", res_strobe, 0);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/nabp_testdata.hex */
// one projection line per row, NUM_S = 16
// columns: angle, sample 0 to sample 15 (12-bit), expected sum (20-bit)
// constant one
000 001 001 001 001 001 001 001 001 001 001 001 001 001 001 001 001 0003A
// constant minus one
02D FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFF FFFC4
// positive full scale
05A 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 1D7C4
// negative full scale
087 800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 E2800
// single impulse at position five
0B4 000 000 000 000 000 064 000 000 000 000 000 000 000 000 000 000 00190
// mixed signs, odd pair sums round down
0E1 005 FFD 000 007 FF8 002 001 000 000 FFF 004 00A FEC 003 000 006 FFFFE

/* files.f */
common/nabp_types_pkg.sv
common/nabp_ctrl_pkg.sv
common/filtered_stream_if.sv
design/projection_filter.sv
filtered_ram/filtered_ram_swappable.sv
filtered_ram/filtered_ram_swap_control.sv
design/backprojection_reader.sv
design/nabp_filtered_top.sv
verification/nabp_filtered_tb.sv

/* Bender.yml */
package:
  name: nabp_filtered

sources:
  # packages and interface first
  - common/nabp_types_pkg.sv
  - common/nabp_ctrl_pkg.sv
  - common/filtered_stream_if.sv
  # design
  - design/projection_filter.sv
  - filtered_ram/filtered_ram_swappable.sv
  - filtered_ram/filtered_ram_swap_control.sv
  - design/backprojection_reader.sv
  - design/nabp_filtered_top.sv
  # testbench
  - target: test
    files:
      - verification/nabp_filtered_tb.sv
